// ==== Bender.yml ====
package:
  name: frame_rd

sources:
  - rtl/frame_rd_pkg.sv
  - rtl/frame_size_calc.sv
  - rtl/rd_cmd_fsm.sv
  - rtl/back_buf_fifo.sv
  - rtl/frame_rd_top.sv
  - target: test
    files:
      - test/frame_rd_assert.sv
      - test/frame_rd_tb.sv

// ==== filelist.f ====
rtl/frame_rd_pkg.sv
rtl/frame_size_calc.sv
rtl/rd_cmd_fsm.sv
rtl/back_buf_fifo.sv
rtl/frame_rd_top.sv
test/frame_rd_assert.sv
test/frame_rd_tb.sv

// ==== rtl/back_buf_fifo.sv ====
/*
 * back buffer FIFO, 64 bit in, 32 bit out
 * each entry leaves as two words, low half first
 */
`default_nettype none

module back_buf_fifo
	import frame_rd_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_flush_n,     // low clears the buffer
	input  logic                 i_wr_en,
	input  logic [DATA_WD-1:0]   iv_wr_data,
	input  logic                 i_rd_en,
	output logic [OUT_WD-1:0]    ov_dout,
	output logic                 o_valid,
	output logic                 o_empty,
	output logic                 o_full,
	output logic                 o_prog_full
);

	logic [DATA_WD-1:0]         mem [0:(1 << FIFO_DEPTH_WD)-1];
	logic [FIFO_DEPTH_WD-1:0]   wr_ptr;
	logic [FIFO_DEPTH_WD-1:0]   rd_ptr;
	logic [FIFO_DEPTH_WD:0]     count;        // entries held, 0..256
	logic                       half_sel;     // 0 low half next, 1 high half next
	logic                       push;
	logic                       rd_ok;        // a 32 bit word goes out
	logic                       pop;          // entry retired after its high half

	assign push  = i_wr_en && !o_full && i_flush_n;
	assign rd_ok = i_rd_en && !o_empty && i_flush_n;
	assign pop   = rd_ok && half_sel;

	// flags straight from occupancy
	assign o_empty     = (count == '0);
	assign o_full      = count[FIFO_DEPTH_WD];
	assign o_prog_full = (count >= FIFO_PROG_FULL);

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= iv_wr_data;
	end

	always_ff @(posedge clk)
	begin
		if (rd_ok)
		begin
			if (half_sel)
				ov_dout <= mem[rd_ptr][DATA_WD-1:OUT_WD];
			else
				ov_dout <= mem[rd_ptr][OUT_WD-1:0];
		end
	end

	// --------------------------------------------------
	// pointers, count and output valid
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset || !i_flush_n)
		begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			half_sel <= 1'b0;
			o_valid  <= 1'b0;
		end
		else
		begin
			o_valid <= rd_ok;   // data one cycle after the read
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				half_sel <= !half_sel;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;      // none or both
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/frame_rd_pkg.sv ====
/*
 * frame buffer read engine shared constants
 * port widths, frame geometry values and the read FSM state encoding
 */
`default_nettype none

package frame_rd_pkg;

	// --------------------------------------------------
	// data path widths
	// --------------------------------------------------
	localparam int DATA_WD      = 64;   // memory port word
	localparam int OUT_WD       = 32;   // back buffer output word
	localparam int BUF_DEPTH_WD = 3;    // frame pointer, up to 8 frames
	localparam int ADDR_WD      = 16;   // burst address within a frame
	localparam int FSIZE_WD     = 25;   // byte counts, up to 32 MB frames
	localparam int BSIZE_WD     = 9;    // byte offset inside a 512 byte burst
	localparam int WORD_SHIFT   = 3;    // 8 bytes per port word

	localparam logic [6:0] BURST_WORDS = 7'd64;   // port words per burst

	// --------------------------------------------------
	// frame geometry
	// --------------------------------------------------
	localparam logic [FSIZE_WD-1:0] LEADER_BYTES        = 25'h34;
	localparam logic [6:0]          TRAILER_BYTES       = 7'h20;   // chunk off
	localparam logic [6:0]          TRAILER_CHUNK_BYTES = 7'h24;   // chunk on

	// trailer sits at a fixed burst near the top of the frame slot
	localparam logic [ADDR_WD-1:0] TRAILER_ADDR = {{(ADDR_WD-1){1'b1}}, 1'b0};

	// --------------------------------------------------
	// memory controller command fields
	// --------------------------------------------------
	localparam logic [2:0] CMD_INSTR_RD = 3'd1;   // read
	localparam logic [5:0] CMD_BL       = 6'd63;  // 64 words per burst
	localparam int         CMD_ADDR_WD  = 30;

	// back buffer, 256 x 64
	localparam int FIFO_DEPTH_WD  = 8;
	localparam int FIFO_PROG_FULL = 180;  // stop issuing bursts above this

	// read command FSM
	typedef enum logic [2:0] {
		S_IDLE,
		S_REQ_WAIT,
		S_REQ,
		S_CMD_WAIT,
		S_CMD,
		S_RD,
		S_CHK
	} rd_state_e;

endpackage

`default_nettype wire

// ==== rtl/frame_rd_top.sv ====
/*
 * frame buffer read engine top
 * size calc, command FSM and back buffer between the memory read port and the output
 */
`default_nettype none

module frame_rd_top
	import frame_rd_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	// acquisition and frame settings
	input  logic                      i_se_2_fvalrise,
	input  logic [BUF_DEPTH_WD-1:0]   iv_frame_depth,
	input  logic [FSIZE_WD-1:0]       iv_payload_size,
	input  logic                      i_chunkmodeactive,
	// writer position
	input  logic [BUF_DEPTH_WD-1:0]   iv_wr_frame_ptr,
	input  logic [ADDR_WD-1:0]        iv_wr_addr,
	output logic [BUF_DEPTH_WD-1:0]   ov_rd_frame_ptr,
	// memory controller read port
	input  logic                      i_p_out_cmd_empty,
	output logic                      o_p_out_cmd_en,
	output logic [2:0]                ov_p_out_cmd_instr,
	output logic [5:0]                ov_p_out_cmd_bl,
	output logic [CMD_ADDR_WD-1:0]    ov_p_out_cmd_byte_addr,
	input  logic [DATA_WD-1:0]        iv_p_out_rd_data,
	input  logic                      i_p_out_rd_empty,
	output logic                      o_p_out_rd_en,
	// output side
	input  logic                      i_buf_rd,
	output logic                      o_back_buf_empty,
	output logic                      o_frame_valid,
	output logic [OUT_WD-1:0]         ov_frame_dout
);

	// --------------------------------------------------
	// internal links
	// --------------------------------------------------
	logic                          acq_active;
	logic [FSIZE_WD-WORD_SHIFT:0]  lp_words;
	logic [6:0]                    trailer_words;
	logic [ADDR_WD-1:0]            last_pl_addr;
	logic                          buf_wr_en;
	logic [DATA_WD-1:0]            buf_wr_data;
	logic                          buf_full;
	logic                          buf_prog_full;

	assign ov_p_out_cmd_instr = CMD_INSTR_RD;   // read only port
	assign ov_p_out_cmd_bl    = CMD_BL;         // fixed 64 word bursts

	frame_size_calc frame_size_calc_inst (
		.clk               (clk),
		.reset             (reset),
		.i_acq_active      (acq_active),
		.iv_payload_size   (iv_payload_size),
		.i_chunkmodeactive (i_chunkmodeactive),
		.ov_lp_words       (lp_words),
		.ov_trailer_words  (trailer_words),
		.ov_last_pl_addr   (last_pl_addr)
	);

	rd_cmd_fsm rd_cmd_fsm_inst (
		.clk               (clk),
		.reset             (reset),
		.i_se_2_fvalrise   (i_se_2_fvalrise),
		.iv_frame_depth    (iv_frame_depth),
		.iv_wr_frame_ptr   (iv_wr_frame_ptr),
		.iv_wr_addr        (iv_wr_addr),
		.i_p_out_cmd_empty (i_p_out_cmd_empty),
		.iv_p_out_rd_data  (iv_p_out_rd_data),
		.i_p_out_rd_empty  (i_p_out_rd_empty),
		.iv_lp_words       (lp_words),
		.iv_trailer_words  (trailer_words),
		.iv_last_pl_addr   (last_pl_addr),
		.i_buf_full        (buf_full),
		.i_buf_prog_full   (buf_prog_full),
		.o_acq_active      (acq_active),
		.o_cmd_en          (o_p_out_cmd_en),
		.ov_cmd_byte_addr  (ov_p_out_cmd_byte_addr),
		.o_rd_en           (o_p_out_rd_en),
		.o_buf_wr_en       (buf_wr_en),
		.ov_buf_wr_data    (buf_wr_data),
		.ov_rd_frame_ptr   (ov_rd_frame_ptr)
	);

	// flushed whenever acquisition is stopped
	back_buf_fifo back_buf_fifo_inst (
		.clk         (clk),
		.reset       (reset),
		.i_flush_n   (acq_active),
		.i_wr_en     (buf_wr_en),
		.iv_wr_data  (buf_wr_data),
		.i_rd_en     (i_buf_rd),
		.ov_dout     (ov_frame_dout),
		.o_valid     (o_frame_valid),
		.o_empty     (o_back_buf_empty),
		.o_full      (buf_full),
		.o_prog_full (buf_prog_full)
	);

endmodule

`default_nettype wire

// ==== rtl/frame_size_calc.sv ====
/*
 * frame size calculation
 * latches leader+payload and trailer sizes while stopped, derives word and burst counts
 */
`default_nettype none

module frame_size_calc
	import frame_rd_pkg::*;
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          i_acq_active,      // low while stopped
	input  logic [FSIZE_WD-1:0]           iv_payload_size,
	input  logic                          i_chunkmodeactive,
	output logic [FSIZE_WD-WORD_SHIFT:0]  ov_lp_words,       // leader+payload words, rounded up
	output logic [6:0]                    ov_trailer_words,
	output logic [ADDR_WD-1:0]            ov_last_pl_addr    // burst addr of last payload burst
);

	logic [FSIZE_WD-1:0] lp_bytes;       // leader + payload bytes
	logic [6:0]          trailer_bytes;
	logic [FSIZE_WD-1:0] lp_bytes_m1;    // for the last burst index

	// --------------------------------------------------
	// stage 1, byte sizes, only updated while stopped
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lp_bytes      <= LEADER_BYTES;
			trailer_bytes <= TRAILER_BYTES;
		end
		else if (!i_acq_active)
		begin
			lp_bytes <= iv_payload_size + LEADER_BYTES;
			// chunk mode adds 4 bytes to the trailer
			if (i_chunkmodeactive)
				trailer_bytes <= TRAILER_CHUNK_BYTES;
			else
				trailer_bytes <= TRAILER_BYTES;
		end
	end

	assign lp_bytes_m1 = lp_bytes - 1'b1;

	// --------------------------------------------------
	// stage 2, word and burst counts
	// --------------------------------------------------
	// sizes are multiples of 4, so bit 2 alone decides the round up
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ov_lp_words      <= '0;
			ov_trailer_words <= '0;
			ov_last_pl_addr  <= '0;
		end
		else
		begin
			ov_lp_words      <= {1'b0, lp_bytes[FSIZE_WD-1:WORD_SHIFT]}
				+ lp_bytes[WORD_SHIFT-1];
			ov_trailer_words <= {{WORD_SHIFT{1'b0}}, trailer_bytes[6:WORD_SHIFT]}
				+ trailer_bytes[WORD_SHIFT-1];
			ov_last_pl_addr  <= lp_bytes_m1[FSIZE_WD-1:BSIZE_WD];   // (bytes-1)/512
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rd_cmd_fsm.sv ====
/*
 * read command engine
 * burst command FSM, frame pointer and burst address, port read gating and padding filter
 */
`default_nettype none

module rd_cmd_fsm
	import frame_rd_pkg::*;
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          i_se_2_fvalrise,    // acquisition level, async-ish
	input  logic [BUF_DEPTH_WD-1:0]       iv_frame_depth,
	input  logic [BUF_DEPTH_WD-1:0]       iv_wr_frame_ptr,
	input  logic [ADDR_WD-1:0]            iv_wr_addr,
	input  logic                          i_p_out_cmd_empty,
	input  logic [DATA_WD-1:0]            iv_p_out_rd_data,
	input  logic                          i_p_out_rd_empty,
	input  logic [FSIZE_WD-WORD_SHIFT:0]  iv_lp_words,
	input  logic [6:0]                    iv_trailer_words,
	input  logic [ADDR_WD-1:0]            iv_last_pl_addr,
	input  logic                          i_buf_full,
	input  logic                          i_buf_prog_full,
	output logic                          o_acq_active,
	output logic                          o_cmd_en,
	output logic [CMD_ADDR_WD-1:0]        ov_cmd_byte_addr,
	output logic                          o_rd_en,
	output logic                          o_buf_wr_en,
	output logic [DATA_WD-1:0]            ov_buf_wr_data,
	output logic [BUF_DEPTH_WD-1:0]       ov_rd_frame_ptr
);

	rd_state_e                     state;
	rd_state_e                     next_state;
	logic [1:0]                    acq_sync;          // 2 flop sync of acquisition level
	logic                          able_to_read;      // data in ddr ahead of the reader
	logic [ADDR_WD-1:0]            rd_addr;           // burst address in frame
	logic [6:0]                    word_cnt;          // words taken in current burst
	logic [FSIZE_WD-WORD_SHIFT:0]  frame_word_cnt;    // payload words taken in frame
	logic                          reading_trailer;   // current burst is the trailer
	logic                          wr_payload;
	logic                          wr_trailer;

	// --------------------------------------------------
	// acquisition sync and availability
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			acq_sync <= 2'b00;
		else
			acq_sync <= {acq_sync[0], i_se_2_fvalrise};
	end

	assign o_acq_active = acq_sync[1];

	// other frame: readable once the writer has started it
	// same frame: readable while behind the writer
	always_ff @(posedge clk)
	begin
		if (reset)
			able_to_read <= 1'b0;
		else if (iv_wr_frame_ptr != ov_rd_frame_ptr)
			able_to_read <= (iv_wr_addr != '0);
		else
			able_to_read <= (rd_addr < iv_wr_addr);
	end

	// --------------------------------------------------
	// FSM
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			state <= S_IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			S_IDLE:
				if (able_to_read && !i_buf_prog_full && o_acq_active)
					next_state = S_REQ_WAIT;
			S_REQ_WAIT:
				next_state = o_acq_active ? S_REQ : S_IDLE;
			S_REQ:
				next_state = S_CMD_WAIT;      // pointer moves here
			S_CMD_WAIT:
				if (!o_acq_active)
					next_state = S_IDLE;
				else if (i_p_out_cmd_empty && !i_buf_prog_full && able_to_read)
					next_state = S_CMD;
			S_CMD:
				next_state = S_RD;
			S_RD:
				// burst always drains fully, even when stopping
				if (word_cnt == BURST_WORDS)
					next_state = o_acq_active ? S_CHK : S_IDLE;
			S_CHK:
				if (!o_acq_active || reading_trailer)
					next_state = S_IDLE;      // trailer done, frame complete
				else
					next_state = S_CMD_WAIT;
			default:
				next_state = S_IDLE;
		endcase
	end

	// one cycle pulse, cycle after S_CMD
	always_ff @(posedge clk)
	begin
		if (reset)
			o_cmd_en <= 1'b0;
		else
			o_cmd_en <= (state == S_CMD);
	end

	// --------------------------------------------------
	// frame pointer and burst address
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			ov_rd_frame_ptr <= '0;
		else if (state == S_IDLE && !o_acq_active)
			ov_rd_frame_ptr <= '0;                       // stopped, back to frame 0
		else if (state == S_REQ && ov_rd_frame_ptr != iv_wr_frame_ptr)
		begin
			if (ov_rd_frame_ptr == iv_frame_depth - 1'b1)
				ov_rd_frame_ptr <= '0;                   // wrap at depth
			else
				ov_rd_frame_ptr <= ov_rd_frame_ptr + 1'b1;
		end
	end

	// address steps once per issued command
	always_ff @(posedge clk)
	begin
		if (reset)
			rd_addr <= '0;
		else if ((state == S_IDLE && !o_acq_active) || state == S_REQ)
			rd_addr <= '0;
		else if (o_cmd_en && rd_addr != TRAILER_ADDR)
		begin
			if (rd_addr == iv_last_pl_addr)
				rd_addr <= TRAILER_ADDR;    // payload done, trailer next
			else
				rd_addr <= rd_addr + 1'b1;
		end
	end

	assign ov_cmd_byte_addr = {2'b00, ov_rd_frame_ptr, rd_addr, {BSIZE_WD{1'b0}}};

	// trailer flag follows the address of the burst being issued
	always_ff @(posedge clk)
	begin
		if (reset)
			reading_trailer <= 1'b0;
		else if (state == S_CMD)
			reading_trailer <= (rd_addr == TRAILER_ADDR);
		else if (state == S_IDLE)
			reading_trailer <= 1'b0;
	end

	// --------------------------------------------------
	// port read gating and word counters
	// --------------------------------------------------
	assign o_rd_en = !i_p_out_rd_empty && !i_buf_full && (word_cnt < BURST_WORDS);

	always_ff @(posedge clk)
	begin
		if (reset)
			word_cnt <= BURST_WORDS;    // parked at 64, no reads outside a burst
		else if (state == S_CMD)
			word_cnt <= '0;
		else if (o_rd_en)
			word_cnt <= word_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			frame_word_cnt <= '0;
		else if (state == S_REQ)
			frame_word_cnt <= '0;           // new frame
		else if (o_rd_en && !reading_trailer)
			frame_word_cnt <= frame_word_cnt + 1'b1;
	end

	// drop padding at the tail of the last payload burst and of the trailer burst
	assign wr_payload = o_rd_en && !reading_trailer && (frame_word_cnt < iv_lp_words);
	assign wr_trailer = o_rd_en && reading_trailer && (word_cnt < iv_trailer_words);

	assign o_buf_wr_en    = wr_payload || wr_trailer;
	assign ov_buf_wr_data = iv_p_out_rd_data;   // written the same cycle it is popped

endmodule

`default_nettype wire

// ==== test/frame_rd_assert.sv ====
/*
 * read engine protocol checks, bound into rd_cmd_fsm
 */
`default_nettype none

module frame_rd_assert
	import frame_rd_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  rd_state_e  state,
	input  logic       o_cmd_en,
	input  logic       o_rd_en,
	input  logic       i_buf_full,
	input  logic       i_buf_prog_full
);

	// command strobe is a single cycle pulse
	cmd_pulse_a: assert property (@(posedge clk) disable iff (reset)
		o_cmd_en |=> !o_cmd_en)
		else $error("command enable held longer than one cycle");

	full_rd_a: assert property (@(posedge clk) disable iff (reset)
		i_buf_full |-> !o_rd_en)
		else $error("port read while back buffer full");

	// no new burst once the buffer is near full
	prog_full_cmd_a: assert property (@(posedge clk) disable iff (reset)
		(state == S_CMD_WAIT && i_buf_prog_full) |=> (state != S_CMD))
		else $error("command issued while back buffer prog full");

endmodule

bind rd_cmd_fsm frame_rd_assert frame_rd_assert_inst (
	.clk             (clk),
	.reset           (reset),
	.state           (state),
	.o_cmd_en        (o_cmd_en),
	.o_rd_en         (o_rd_en),
	.i_buf_full      (i_buf_full),
	.i_buf_prog_full (i_buf_prog_full)
);

`default_nettype wire

// ==== test/frame_rd_tb.sv ====
/*
 * frame read engine testbench
 * memory read port model, output reader and directed frame tests
 */
`default_nettype none

module frame_rd_tb
	import frame_rd_pkg::*;
();

	localparam logic [31:0] RNG_SEED       = 32'hc70bd29a;
	localparam int          BURST_BYTES    = int'(BURST_WORDS) << WORD_SHIFT;   // 512
	localparam int          PORT_STALL_PCT = 20;

	logic                      clk               = 1'b0;
	logic                      reset             = 1'b1;
	logic                      i_se_2_fvalrise   = 1'b0;
	logic [BUF_DEPTH_WD-1:0]   iv_frame_depth    = 3'd4;
	logic [FSIZE_WD-1:0]       iv_payload_size   = '0;
	logic                      i_chunkmodeactive = 1'b0;
	logic [BUF_DEPTH_WD-1:0]   iv_wr_frame_ptr   = '0;
	logic [ADDR_WD-1:0]        iv_wr_addr        = '0;
	logic                      i_p_out_cmd_empty = 1'b1;   // cmd queue always drained
	logic [DATA_WD-1:0]        iv_p_out_rd_data  = '0;
	logic                      i_p_out_rd_empty  = 1'b1;
	logic                      i_buf_rd          = 1'b0;
	logic [BUF_DEPTH_WD-1:0]   ov_rd_frame_ptr;
	logic                      o_p_out_cmd_en;
	logic [2:0]                ov_p_out_cmd_instr;
	logic [5:0]                ov_p_out_cmd_bl;
	logic [CMD_ADDR_WD-1:0]    ov_p_out_cmd_byte_addr;
	logic                      o_p_out_rd_en;
	logic                      o_back_buf_empty;
	logic                      o_frame_valid;
	logic [OUT_WD-1:0]         ov_frame_dout;

	logic [DATA_WD-1:0]        port_q[$];      // words sitting in the read port
	logic [CMD_ADDR_WD-1:0]    cmd_log[$];     // every command seen
	logic [OUT_WD-1:0]         rx_q[$];        // every output word seen
	logic [CMD_ADDR_WD-1:0]    exp_cmds[$];
	logic [OUT_WD-1:0]         exp_words[$];
	int                        cmd_count      = 0;
	int                        rx_count       = 0;
	int                        rd_stall_pct   = 20;
	int                        n_checks       = 0;
	int                        n_errors       = 0;
	int                        cur_payload;
	bit                        cur_chunk;
	logic [BUF_DEPTH_WD-1:0]   cur_depth;
	logic [BUF_DEPTH_WD-1:0]   exp_ptr;

	always #5 clk = ~clk;

	frame_rd_top frame_rd_top_inst (.*);

	// port word: command address on top, word index below
	function automatic logic [DATA_WD-1:0] port_word(input logic [CMD_ADDR_WD-1:0] addr,
		input int idx);
		return {2'b00, addr, 32'(idx)};
	endfunction

	// --------------------------------------------------
	// memory read port model
	// --------------------------------------------------
	always @(posedge clk)
	begin
		if (reset)
		begin
			port_q.delete();
			i_p_out_rd_empty <= 1'b1;
		end
		else
		begin
			if (o_p_out_rd_en && port_q.size() == 0)
			begin
				n_errors++;
				$display("port read while the read port held no data");
			end
			else if (o_p_out_rd_en)
				void'(port_q.pop_front());
			if (o_p_out_cmd_en)
			begin
				cmd_instr_eq("ov_p_out_cmd_instr", ov_p_out_cmd_instr, 3'd1);   // read
				// length code is burst words minus one
				cmd_bl_eq("ov_p_out_cmd_bl", ov_p_out_cmd_bl, 6'(int'(BURST_WORDS) - 1));
				cmd_log.push_back(ov_p_out_cmd_byte_addr);
				cmd_count <= cmd_count + 1;
				for (int i = 0; i < int'(BURST_WORDS); i++)
					port_q.push_back(port_word(ov_p_out_cmd_byte_addr, i));
			end
			if (port_q.size() > 0)
				iv_p_out_rd_data <= port_q[0];
			// random gaps even with data queued
			i_p_out_rd_empty <= (port_q.size() == 0) || (($urandom % 100) < PORT_STALL_PCT);
		end
	end

	// output side reader and collector
	always @(posedge clk)
	begin
		if (reset)
			i_buf_rd <= 1'b0;
		else
		begin
			i_buf_rd <= ($urandom % 100) >= rd_stall_pct;
			if (o_frame_valid)
			begin
				rx_q.push_back(ov_frame_dout);
				rx_count <= rx_count + 1;
			end
		end
	end

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic word_eq(input string name, input logic [OUT_WD-1:0] got,
		input logic [OUT_WD-1:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("** Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic cmd_addr_eq(input string name, input logic [CMD_ADDR_WD-1:0] got,
		input logic [CMD_ADDR_WD-1:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("** Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic cmd_instr_eq(input string name, input logic [2:0] got,
		input logic [2:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("** Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic cmd_bl_eq(input string name, input logic [5:0] got,
		input logic [5:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("** Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic frame_ptr_eq(input string name, input logic [BUF_DEPTH_WD-1:0] got,
		input logic [BUF_DEPTH_WD-1:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("** Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic level_eq(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("** Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int e0);
		if (n_errors == e0)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, n_errors - e0);
	endtask

	// --------------------------------------------------
	// expected frame from the size rules
	// --------------------------------------------------
	task automatic build_expected(input logic [BUF_DEPTH_WD-1:0] ptr);
		int                      lp_bytes;
		int                      lp_words;
		int                      last_pl;
		int                      tr_words;
		int                      kept;
		logic [ADDR_WD-1:0]      burst;
		logic [CMD_ADDR_WD-1:0]  addr;
		logic [DATA_WD-1:0]      w;
		lp_bytes = cur_payload + int'(LEADER_BYTES);
		lp_words = (lp_bytes + 7) / 8;                  // 8 byte port words
		last_pl  = (lp_bytes - 1) / BURST_BYTES;
		tr_words = (int'(cur_chunk ? TRAILER_CHUNK_BYTES : TRAILER_BYTES) + 7) / 8;
		kept     = 0;
		exp_cmds.delete();
		exp_words.delete();
		for (int b = 0; b <= last_pl + 1; b++)
		begin
			burst = (b > last_pl) ? TRAILER_ADDR : ADDR_WD'(b);   // one trailer burst at the end
			addr  = {2'b00, ptr, burst, {BSIZE_WD{1'b0}}};
			exp_cmds.push_back(addr);
			for (int i = 0; i < int'(BURST_WORDS); i++)
			begin
				w = port_word(addr, i);
				if ((b > last_pl) ? (i < tr_words) : (kept < lp_words))
				begin
					exp_words.push_back(w[OUT_WD-1:0]);          // low half first
					exp_words.push_back(w[DATA_WD-1:OUT_WD]);
				end
				if (b <= last_pl)
					kept++;
			end
		end
	endtask

	// stop, wait for flush and pointer reset, load geometry, restart
	task automatic stop_and_config(input logic [BUF_DEPTH_WD-1:0] depth, input int payload,
		input bit chunk);
		int cyc;
		i_se_2_fvalrise <= 1'b0;
		iv_wr_frame_ptr <= '0;      // writer parked, nothing readable
		iv_wr_addr      <= '0;
		repeat (3) @(posedge clk);  // acquisition sync delay
		cyc = 0;
		while (!(o_back_buf_empty && ov_rd_frame_ptr == '0) && cyc < 5000)
		begin
			@(posedge clk);
			cyc++;
		end
		if (cyc >= 5000)
		begin
			n_errors++;
			$display("engine did not go idle after acquisition stopped");
		end
		iv_payload_size   <= FSIZE_WD'(payload);
		i_chunkmodeactive <= chunk;
		iv_frame_depth    <= depth;
		cur_payload = payload;
		cur_chunk   = chunk;
		cur_depth   = depth;
		exp_ptr     = '0;
		repeat (6) @(posedge clk);  // geometry settle
		i_se_2_fvalrise <= 1'b1;
		repeat (3) @(posedge clk);
	endtask

	// release one frame from the writer and check what comes out
	task automatic run_frame(input logic [BUF_DEPTH_WD-1:0] wr_ptr_next, input int limit);
		int rx_base;
		int cmd_base;
		int cyc;
		int e1;
		// next slot modulo the buffer depth
		if (exp_ptr != wr_ptr_next)
			exp_ptr = BUF_DEPTH_WD'((int'(exp_ptr) + 1) % int'(cur_depth));
		build_expected(exp_ptr);
		rx_base  = rx_count;
		cmd_base = cmd_count;
		iv_wr_frame_ptr <= wr_ptr_next;
		iv_wr_addr      <= 16'hffff;   // whole frame written
		cyc = 0;
		while (rx_count - rx_base < exp_words.size() && cyc < limit)
		begin
			@(posedge clk);
			// writer holds at the trailer once the reader reaches it
			if (o_p_out_cmd_en && ov_p_out_cmd_byte_addr[BSIZE_WD +: ADDR_WD] == TRAILER_ADDR)
				iv_wr_addr <= TRAILER_ADDR;
			cyc++;
		end
		if (cyc >= limit)
		begin
			n_errors++;
			$display("timeout: frame on pointer %0d gave %0d of %0d words", exp_ptr,
				rx_count - rx_base, exp_words.size());
			return;
		end
		repeat (150) @(posedge clk);   // room for a stray burst
		if (cmd_count - cmd_base != exp_cmds.size())
		begin
			n_errors++;
			$display("frame on pointer %0d issued %0d commands instead of %0d", exp_ptr,
				cmd_count - cmd_base, exp_cmds.size());
		end
		else
		begin
			e1 = n_errors;
			for (int k = 0; k < exp_cmds.size(); k++)
			begin
				cmd_addr_eq("ov_p_out_cmd_byte_addr", cmd_log[cmd_base + k], exp_cmds[k]);
				if (n_errors != e1)
					break;
			end
		end
		if (rx_count - rx_base != exp_words.size())
		begin
			n_errors++;
			$display("frame on pointer %0d gave %0d words instead of %0d", exp_ptr,
				rx_count - rx_base, exp_words.size());
		end
		else
		begin
			e1 = n_errors;
			for (int k = 0; k < exp_words.size(); k++)
			begin
				word_eq("ov_frame_dout", rx_q[rx_base + k], exp_words[k]);
				if (n_errors != e1)
					break;
			end
		end
		frame_ptr_eq("ov_rd_frame_ptr", ov_rd_frame_ptr, exp_ptr);
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic after_reset();
		int e0;
		int c0;
		e0 = n_errors;
		@(posedge clk);
		level_eq("o_p_out_cmd_en", o_p_out_cmd_en, 1'b0);
		level_eq("o_p_out_rd_en", o_p_out_rd_en, 1'b0);
		level_eq("o_frame_valid", o_frame_valid, 1'b0);
		level_eq("o_back_buf_empty", o_back_buf_empty, 1'b1);
		frame_ptr_eq("ov_rd_frame_ptr", ov_rd_frame_ptr, '0);
		c0 = cmd_count;
		iv_wr_frame_ptr <= 3'd1;   // data waiting, still stopped
		iv_wr_addr      <= 16'hffff;
		repeat (200) @(posedge clk);
		if (cmd_count != c0)
		begin
			n_errors++;
			$display("command issued while acquisition was stopped");
		end
		iv_wr_frame_ptr <= '0;     // running, nothing written
		iv_wr_addr      <= '0;
		repeat (4) @(posedge clk);
		i_se_2_fvalrise <= 1'b1;
		repeat (200) @(posedge clk);
		if (cmd_count != c0)
		begin
			n_errors++;
			$display("command issued with no frame data available");
		end
		report_test("after reset", e0);
	endtask

	task automatic single_frame();
		int e0;
		e0 = n_errors;
		stop_and_config(3'd4, 1000, 1'b0);
		run_frame(3'd1, 8000);
		stop_and_config(3'd4, 972, 1'b0);   // leader+payload exactly 1024 bytes
		run_frame(3'd1, 8000);
		report_test("one frame, chunk off", e0);
	endtask

	task automatic chunk_frame();
		int e0;
		e0 = n_errors;
		stop_and_config(3'd4, 1000, 1'b1);
		run_frame(3'd1, 8000);
		report_test("one frame, chunk on", e0);
	endtask

	task automatic pointer_wrap();
		int e0;
		e0 = n_errors;
		stop_and_config(3'd3, 200, 1'b0);
		run_frame(3'd1, 8000);
		run_frame(3'd2, 8000);
		run_frame(3'd0, 8000);     // wraps at depth-1
		run_frame(3'd1, 8000);
		report_test("frame pointer wrap", e0);
	endtask

	task automatic back_pressure();
		int e0;
		e0 = n_errors;
		rd_stall_pct <= 90;
		stop_and_config(3'd4, 4096, 1'b0);
		run_frame(3'd1, 80000);
		rd_stall_pct <= 20;
		report_test("back-pressure", e0);
	endtask

	task automatic stop_mid_frame();
		int e0;
		int c0;
		int cyc;
		e0 = n_errors;
		rd_stall_pct <= 95;
		stop_and_config(3'd4, 4096, 1'b0);
		c0 = cmd_count;
		iv_wr_frame_ptr <= 3'd1;
		iv_wr_addr      <= 16'hffff;
		cyc = 0;
		while (cmd_count - c0 < 3 && cyc < 20000)
		begin
			@(posedge clk);
			cyc++;
		end
		if (cyc >= 20000)
		begin
			n_errors++;
			$display("timeout waiting for the first bursts of the frame");
		end
		// frame under way, buffer holding words on pointer 1
		level_eq("o_back_buf_empty", o_back_buf_empty, 1'b0);
		frame_ptr_eq("ov_rd_frame_ptr", ov_rd_frame_ptr, 3'd1);
		rd_stall_pct <= 20;
		stop_and_config(3'd4, 200, 1'b0);   // stop mid frame, waits for flush and pointer 0
		run_frame(3'd1, 8000);               // restarts at burst 0
		report_test("stop mid-frame", e0);
	endtask

	initial
	begin
		void'($urandom(RNG_SEED));
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		after_reset();
		single_frame();
		chunk_frame();
		pointer_wrap();
		back_pressure();
		stop_mid_frame();
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire
